/* spi_config.svh */
`ifndef SPI_CONFIG_SVH
`define SPI_CONFIG_SVH

// bits per frame, sent and received msb first
`define SPI_DATA_WIDTH 40

// number of active-low chip-select lines
`define SPI_CS_COUNT 4

// width of the clock divider setting
`define SPI_DIV_WIDTH 3

`endif

/* spi_types_pkg.sv */
`include "spi_config.svh"

package spi_types_pkg;

  // one frame of payload
  typedef logic [`SPI_DATA_WIDTH-1:0] spi_word_t;

  // chip-select lines, one bit per slave
  typedef logic [`SPI_CS_COUNT-1:0] spi_cs_t;

  // index of the chosen chip select
  localparam int unsigned SPI_CS_SEL_WIDTH = $clog2(`SPI_CS_COUNT);
  typedef logic [SPI_CS_SEL_WIDTH-1:0] spi_cs_sel_t;

  // divider setting, tick every value+1 cycles
  typedef logic [`SPI_DIV_WIDTH-1:0] spi_div_t;

  // bits done in a frame, must reach SPI_DATA_WIDTH itself
  localparam int unsigned SPI_BIT_COUNT_WIDTH = $clog2(`SPI_DATA_WIDTH + 1);
  typedef logic [SPI_BIT_COUNT_WIDTH-1:0] spi_bit_count_t;

endpackage

/* spi_ctrl_pkg.sv */
package spi_ctrl_pkg;

  // frame controller states
  // SELECT waits one tick with cs low before the first clk_out edge
  // HOLD keeps cs low for one tick after the last falling edge
  typedef enum logic [2:0] {
    IDLE,
    SELECT,
    SHIFT,
    HOLD,
    DONE
  } spi_state_e;

endpackage

/* spi_clk_divider.sv */
`include "spi_config.svh"

module spi_clk_divider
  import spi_types_pkg::*;
(
  input  logic     clk_in,
  input  logic     reset_n_in,
  input  logic     enable,
  input  spi_div_t clk_count_max,
  output logic     tick
);

  spi_div_t count;
  logic     count_wrap;

  assign count_wrap = (count == clk_count_max);

  // counter restarts from zero whenever enable is low,
  // so every frame sees the same tick phase
  always_ff @(posedge clk_in or negedge reset_n_in) begin
    if (!reset_n_in) begin
      count <= '0;
    end else if (!enable) begin
      count <= '0;
    end else if (count_wrap) begin
      count <= '0;
    end else begin
      count <= count + 1'b1;
    end
  end

  // one-cycle strobe every clk_count_max+1 enabled cycles
  assign tick = enable && count_wrap;

endmodule

/* spi_cs_decoder.sv */
`include "spi_config.svh"

module spi_cs_decoder
  import spi_types_pkg::*;
(
  input  logic        clk_in,
  input  logic        reset_n_in,
  input  spi_cs_sel_t cs_select_in,
  input  logic        cs_active,
  output spi_cs_t     cs_out_n
);

  spi_cs_sel_t sel_q;

  // select is frozen for the whole frame
  always_ff @(posedge clk_in or negedge reset_n_in) begin
    if (!reset_n_in) begin
      sel_q <= '0;
    end else if (!cs_active) begin
      sel_q <= cs_select_in;
    end
  end

  // registered one-hot low output, all high outside a frame
  always_ff @(posedge clk_in or negedge reset_n_in) begin
    if (!reset_n_in) begin
      cs_out_n <= '1;
    end else begin
      cs_out_n <= ~(spi_cs_t'(cs_active) << sel_q);
    end
  end

endmodule

/* spi_shifter.sv */
`include "spi_config.svh"

module spi_shifter
  import spi_types_pkg::*;
(
  input  logic      clk_in,
  input  logic      reset_n_in,
  input  spi_word_t data_in,
  input  logic      load,
  input  logic      shift,
  input  logic      sample,
  input  logic      capture,
  input  logic      serial_in,
  output logic      serial_out,
  output spi_word_t data_out
);

  spi_word_t tx_shift;
  spi_word_t rx_shift;

  // transmit register
  // msb is on the line, the word moves up one bit per falling clk_out edge
  always_ff @(posedge clk_in or negedge reset_n_in) begin
    if (!reset_n_in) begin
      tx_shift <= '0;
    end else if (load) begin
      tx_shift <= data_in;
    end else if (shift) begin
      tx_shift <= {tx_shift[`SPI_DATA_WIDTH-2:0], 1'b0};
    end
  end

  assign serial_out = tx_shift[`SPI_DATA_WIDTH-1];

  // receive register
  // the first bit received ends up in the msb after a full frame
  always_ff @(posedge clk_in) begin
    if (sample) begin
      rx_shift <= {rx_shift[`SPI_DATA_WIDTH-2:0], serial_in};
    end
  end

  // output latch, only updated when a frame completes
  always_ff @(posedge clk_in or negedge reset_n_in) begin
    if (!reset_n_in) begin
      data_out <= '0;
    end else if (capture) begin
      data_out <= rx_shift;
    end
  end

endmodule

/* spi_frame_controller.sv */
`include "spi_config.svh"

module spi_frame_controller
  import spi_types_pkg::*;
  import spi_ctrl_pkg::*;
(
  input  logic clk_in,
  input  logic reset_n_in,
  input  logic send_enable_in,
  input  logic tick,
  output logic div_enable,
  output logic load,
  output logic shift,
  output logic sample,
  output logic capture,
  output logic cs_active,
  output logic sclk,
  output logic ready_out
);

  spi_state_e     state;
  spi_state_e     state_next;
  spi_bit_count_t bit_count;
  spi_bit_count_t bit_count_next;
  logic           sclk_next;
  logic           frame_active;
  logic           last_bit;

  assign last_bit = (bit_count == spi_bit_count_t'(`SPI_DATA_WIDTH));

  always_comb begin
    state_next     = state;
    bit_count_next = bit_count;
    sclk_next      = sclk;
    load           = 1'b0;
    shift          = 1'b0;
    sample         = 1'b0;
    capture        = 1'b0;

    if (state != IDLE && !send_enable_in) begin
      // abort, drop everything without touching data_out
      state_next = IDLE;
      sclk_next  = 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (send_enable_in) begin
            load           = 1'b1;
            bit_count_next = '0;
            state_next     = SELECT;
          end
        end

        SELECT: begin
          if (tick) begin
            state_next = SHIFT;
          end
        end

        SHIFT: begin
          if (tick) begin
            if (!sclk) begin
              // rising edge, slave data is stable here
              sclk_next      = 1'b1;
              sample         = 1'b1;
              bit_count_next = bit_count + 1'b1;
            end else if (last_bit) begin
              sclk_next  = 1'b0;
              state_next = HOLD;
            end else begin
              sclk_next = 1'b0;
              shift     = 1'b1;
            end
          end
        end

        HOLD: begin
          if (tick) begin
            state_next = DONE;
          end
        end

        DONE: begin
          capture    = 1'b1;
          state_next = IDLE;
        end

        default: begin
          state_next = IDLE;
          sclk_next  = 1'b0;
        end
      endcase
    end
  end

  always_ff @(posedge clk_in or negedge reset_n_in) begin
    if (!reset_n_in) begin
      state     <= IDLE;
      bit_count <= '0;
      sclk      <= 1'b0;
    end else begin
      state     <= state_next;
      bit_count <= bit_count_next;
      sclk      <= sclk_next;
    end
  end

  // divider runs and cs is held from SELECT through HOLD
  assign frame_active = (state == SELECT) || (state == SHIFT) || (state == HOLD);
  assign div_enable   = frame_active;
  assign cs_active    = frame_active;
  assign ready_out    = (state == IDLE);

endmodule

/* spi_master.sv */
`include "spi_config.svh"

module spi_master
  import spi_types_pkg::*;
(
  input  logic        clk_in,
  input  logic        reset_n_in,
  input  spi_word_t   data_in,
  input  spi_div_t    clk_count_max,
  input  logic        serial_in,
  input  logic        send_enable_in,
  input  spi_cs_sel_t cs_select_in,
  output spi_word_t   data_out,
  output logic        clk_out,
  output logic        serial_out,
  output spi_cs_t     cs_out_n,
  output logic        ready_out
);

  logic div_enable;
  logic tick;
  logic load;
  logic shift;
  logic sample;
  logic capture;
  logic cs_active;

  // bit-rate strobes
  spi_clk_divider u_divider (
    .clk_in        (clk_in),
    .reset_n_in    (reset_n_in),
    .enable        (div_enable),
    .clk_count_max (clk_count_max),
    .tick          (tick)
  );

  spi_frame_controller u_controller (
    .clk_in         (clk_in),
    .reset_n_in     (reset_n_in),
    .send_enable_in (send_enable_in),
    .tick           (tick),
    .div_enable     (div_enable),
    .load           (load),
    .shift          (shift),
    .sample         (sample),
    .capture        (capture),
    .cs_active      (cs_active),
    .sclk           (clk_out),
    .ready_out      (ready_out)
  );

  // mosi and miso data path
  spi_shifter u_shifter (
    .clk_in     (clk_in),
    .reset_n_in (reset_n_in),
    .data_in    (data_in),
    .load       (load),
    .shift      (shift),
    .sample     (sample),
    .capture    (capture),
    .serial_in  (serial_in),
    .serial_out (serial_out),
    .data_out   (data_out)
  );

  spi_cs_decoder u_cs_decoder (
    .clk_in       (clk_in),
    .reset_n_in   (reset_n_in),
    .cs_select_in (cs_select_in),
    .cs_active    (cs_active),
    .cs_out_n     (cs_out_n)
  );

endmodule

/* spi_master_checker.sv */
`include "spi_config.svh"

module spi_master_checker
  import spi_types_pkg::*;
  import spi_ctrl_pkg::*;
(
  input logic       clk_in,
  input logic       reset_n_in,
  input logic       send_enable_in,
  input logic       clk_out,
  input spi_cs_t    cs_out_n,
  input logic       ready_out,
  input spi_state_e state
);

  int fail_count = 0;

  // a frame addresses one slave at most
  cs_one_low_a : assert property (@(posedge clk_in) disable iff (!reset_n_in)
    $countones(~cs_out_n) <= 1)
    else begin
      $error("more than one chip select low: %b", cs_out_n);
      fail_count++;
    end

  // no clock pulses reach the bus without a selected slave
  clk_needs_cs_a : assert property (@(posedge clk_in) disable iff (!reset_n_in)
    (&cs_out_n) |-> !clk_out)
    else begin
      $error("clk_out high while no chip select is low");
      fail_count++;
    end

  // a dropped enable ends the frame on the next cycle with clk_out low
  abort_to_idle_a : assert property (@(posedge clk_in) disable iff (!reset_n_in)
    (state != IDLE && !send_enable_in) |=> (ready_out && !clk_out))
    else begin
      $error("frame not aborted after send_enable_in dropped");
      fail_count++;
    end

  // clk_out idles low, mode 0
  clk_idle_low_a : assert property (@(posedge clk_in) disable iff (!reset_n_in)
    ready_out |-> !clk_out)
    else begin
      $error("clk_out high while the master is idle");
      fail_count++;
    end

endmodule

bind spi_master spi_master_checker u_checker (
  .clk_in         (clk_in),
  .reset_n_in     (reset_n_in),
  .send_enable_in (send_enable_in),
  .clk_out        (clk_out),
  .cs_out_n       (cs_out_n),
  .ready_out      (ready_out),
  .state          (u_controller.state)
);

/* spi_master_tb.sv */
`include "spi_config.svh"

module spi_master_tb
  import spi_types_pkg::*;
();

  localparam int CLK_PERIOD    = 20;
  localparam int WORD_BITS     = `SPI_DATA_WIDTH;
  localparam int NUM_FRAMES    = 12;
  localparam int FRAME_BOUND   = (2 * WORD_BITS + 4) * 8 * CLK_PERIOD;
  localparam int WATCHDOG_TIME = NUM_FRAMES * FRAME_BOUND + 200 * CLK_PERIOD;

  logic        clk_in;
  logic        reset_n_in;
  spi_word_t   data_in;
  spi_div_t    clk_count_max;
  logic        serial_in;
  logic        send_enable_in;
  spi_cs_sel_t cs_select_in;
  spi_word_t   data_out;
  logic        clk_out;
  logic        serial_out;
  spi_cs_t     cs_out_n;
  logic        ready_out;

  integer seed         = 37902;
  int     errors       = 0;
  int     tests_run    = 0;
  int     tests_failed = 0;
  string  test_name    = "reset";

  // slave and bus monitor state for the frame in progress
  spi_word_t   slave_word;
  int          slave_bit;
  spi_cs_sel_t sel_exp;
  int          cur_max;
  spi_word_t   mosi_word;
  int          rise_count;
  int          fall_count;
  time         last_rise;
  logic        frame_on;
  spi_word_t   exp_data_out;

  spi_master DUT (
    .clk_in         (clk_in),
    .reset_n_in     (reset_n_in),
    .data_in        (data_in),
    .clk_count_max  (clk_count_max),
    .serial_in      (serial_in),
    .send_enable_in (send_enable_in),
    .cs_select_in   (cs_select_in),
    .data_out       (data_out),
    .clk_out        (clk_out),
    .serial_out     (serial_out),
    .cs_out_n       (cs_out_n),
    .ready_out      (ready_out)
  );

  initial begin
    clk_in = 1'b0;
    forever #(CLK_PERIOD / 2) clk_in = ~clk_in;
  end

  initial begin
    #(WATCHDOG_TIME);
    $display("timeout: the run did not finish within %0d time units", WATCHDOG_TIME);
    $display("Result: FAILED");
    $finish;
  end

  // all lines high except the selected one
  function automatic spi_cs_t cs_lines_for(input spi_cs_sel_t sel);
    spi_cs_t lines;
    for (int i = 0; i < `SPI_CS_COUNT; i++) begin
      lines[i] = (i != sel);
    end
    return lines;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("error %s: expected %0h, actual %0h", name, expected, actual);
    end
  endtask

  task automatic report_test(input int errors_before);
    tests_run++;
    if (errors == errors_before) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: %0d errors", test_name, errors - errors_before);
    end
  endtask

  // slave puts its next bit out after each falling clk_out edge
  always @(negedge clk_out) begin
    fall_count++;
    if (frame_on && !cs_out_n[sel_exp] && slave_bit < WORD_BITS - 1) begin
      slave_bit++;
      serial_in <= slave_word[WORD_BITS - 1 - slave_bit];
    end
  end

  // slave records mosi, bit period and select at each rising edge
  always @(posedge clk_out) begin
    if (frame_on) begin
      if (rise_count > 0) begin
        check_value({test_name, " clk_out period"}, 2 * (cur_max + 1) * CLK_PERIOD,
                    $time - last_rise);
      end
      last_rise = $time;
      rise_count++;
      mosi_word = {mosi_word[WORD_BITS-2:0], serial_out};
      check_value({test_name, " cs_out_n at sample"}, cs_lines_for(sel_exp), cs_out_n);
    end
  end

  // only the line chosen at frame start may go low
  always @(negedge clk_in) begin
    if (frame_on && cs_out_n !== '1) begin
      check_value({test_name, " cs_out_n"}, cs_lines_for(sel_exp), cs_out_n);
    end
  end

  task automatic run_frame(input int index, input bit do_abort);
    spi_word_t   word;
    spi_word_t   s_word;
    spi_div_t    div;
    spi_cs_sel_t sel;
    int          change_at;
    int          abort_at;
    int          cycle;
    int          errors_before;

    word      = spi_word_t'({$random(seed), $random(seed)});
    s_word    = spi_word_t'({$random(seed), $random(seed)});
    div       = spi_div_t'($random(seed));
    sel       = spi_cs_sel_t'($random(seed));
    change_at = 2 + ($unsigned($random(seed)) % (WORD_BITS * (int'(div) + 1)));
    abort_at  = 1 + ($unsigned($random(seed)) % (2 * WORD_BITS * (int'(div) + 1)));
    test_name = $sformatf("%s_%0d", do_abort ? "abort" : "frame", index);
    errors_before = errors;

    @(posedge clk_in);
    slave_word = s_word;
    slave_bit  = 0;
    sel_exp    = sel;
    cur_max    = div;
    rise_count = 0;
    fall_count = 0;
    mosi_word  = '0;
    frame_on   = 1'b1;
    data_in        <= word;
    clk_count_max  <= div;
    cs_select_in   <= sel;
    serial_in      <= s_word[WORD_BITS-1];
    send_enable_in <= 1'b1;

    cycle = 0;
    if (do_abort) begin
      while (cycle < abort_at) begin
        @(posedge clk_in);
        cycle++;
        if (cycle == change_at) begin
          cs_select_in <= sel + 1'b1;
        end
      end
      send_enable_in <= 1'b0;
      do begin
        @(negedge clk_in);
      end while (!ready_out || cs_out_n !== '1);
      frame_on = 1'b0;
      check_value({test_name, " data_out kept"}, exp_data_out, data_out);
      check_value({test_name, " clk_out idle"}, 1'b0, clk_out);
    end else begin
      while (fall_count < WORD_BITS) begin
        @(posedge clk_in);
        cycle++;
        if (cycle == change_at) begin
          cs_select_in <= sel + 1'b1;
        end
        @(negedge clk_in);
      end
      // one tick of HOLD, then the single DONE cycle
      repeat (cur_max + 2) @(posedge clk_in);
      send_enable_in <= 1'b0;
      do begin
        @(negedge clk_in);
      end while (!ready_out);
      frame_on = 1'b0;
      exp_data_out = s_word;
      check_value({test_name, " rising edges"}, WORD_BITS, rise_count);
      check_value({test_name, " mosi word"}, word, mosi_word);
      check_value({test_name, " data_out"}, exp_data_out, data_out);
      check_value({test_name, " cs_out_n released"}, {`SPI_CS_COUNT{1'b1}}, cs_out_n);
      check_value({test_name, " clk_out idle"}, 1'b0, clk_out);
    end
    report_test(errors_before);
  endtask

  initial begin
    int errors_before;

    reset_n_in     = 1'b0;
    data_in        = '0;
    clk_count_max  = '0;
    serial_in      = 1'b0;
    send_enable_in = 1'b0;
    cs_select_in   = '0;
    frame_on       = 1'b0;
    slave_bit      = WORD_BITS - 1;
    sel_exp        = '0;
    exp_data_out   = '0;
    repeat (3) @(posedge clk_in);
    reset_n_in <= 1'b1;

    @(negedge clk_in);
    errors_before = errors;
    check_value("reset ready_out", 1'b1, ready_out);
    check_value("reset clk_out", 1'b0, clk_out);
    check_value("reset cs_out_n", {`SPI_CS_COUNT{1'b1}}, cs_out_n);
    check_value("reset serial_out", 1'b0, serial_out);
    check_value("reset data_out", '0, data_out);
    report_test(errors_before);

    // every fourth frame is cut short
    for (int i = 0; i < NUM_FRAMES; i++) begin
      run_frame(i, (i % 4) == 2);
    end

    $display("tests run: %0d, failed: %0d, errors: %0d, assertion failures: %0d",
             tests_run, tests_failed, errors, DUT.u_checker.fail_count);
    if (errors == 0 && DUT.u_checker.fail_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* all.f */
+incdir+.
spi_types_pkg.sv
spi_ctrl_pkg.sv
spi_clk_divider.sv
spi_cs_decoder.sv
spi_shifter.sv
spi_frame_controller.sv
spi_master.sv
spi_master_checker.sv
spi_master_tb.sv

/* Bender.yml */
package:
  name: spi_master

sources:
  - include_dirs:
      - .
    files:
      - spi_types_pkg.sv
      - spi_ctrl_pkg.sv
      - spi_clk_divider.sv
      - spi_cs_decoder.sv
      - spi_shifter.sv
      - spi_frame_controller.sv
      - spi_master.sv
  - target: test
    include_dirs:
      - .
    files:
      - spi_master_checker.sv
      - spi_master_tb.sv
